//--- common/xlat_pkg.sv
// Address, length and id types, page constants and beat/fault records
package xlat_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int VADDR_BITS = 32;
    localparam int PADDR_BITS = 32;
    localparam int LEN_BITS   = 16;
    localparam int PID_BITS   = 4;

    // 256 byte pages so that requests split often
    localparam int PAGE_BITS  = 8;
    localparam int PAGE_SIZE  = 1 << PAGE_BITS;

    localparam int VPN_BITS   = VADDR_BITS - PAGE_BITS;
    localparam int PPN_BITS   = PADDR_BITS - PAGE_BITS;

    // ----------------------------------------
    // Types
    // ----------------------------------------
    typedef logic [VADDR_BITS-1:0] vaddr_t;
    typedef logic [PADDR_BITS-1:0] paddr_t;
    typedef logic [LEN_BITS-1:0]   len_t;
    typedef logic [PID_BITS-1:0]   pid_t;
    typedef logic [VPN_BITS-1:0]   vpn_t;
    typedef logic [PPN_BITS-1:0]   ppn_t;
    typedef logic [PAGE_BITS-1:0]  offs_t;

    // One physical beat as seen on the dma port
    typedef struct packed {
        paddr_t paddr;
        len_t   len;
        logic   last;
    } beat_t;

    // Contents of one page fault report
    typedef struct packed {
        pid_t   pid;
        vaddr_t vaddr;
        len_t   len;
    } fault_t;

endpackage

//--- logic/dma_issue.sv
// DMA beat issue, outstanding beat queue and completion pulses
module dma_issue import xlat_pkg::*; #(
    parameter int N_OUTSTANDING = 4
) (
    input  logic   aclk,
    input  logic   aresetn,

    // Beats from the FSM
    input  logic   beat_valid,
    output logic   beat_ready,
    input  paddr_t beat_paddr,
    input  len_t   beat_len,
    input  logic   beat_last,
    input  pid_t   beat_pid,

    // DMA port
    output logic   dma_req,
    input  logic   dma_ack,
    output paddr_t dma_paddr,
    output len_t   dma_len,
    output logic   dma_last,
    input  logic   dma_done,

    // Completions
    output logic   done_valid,
    output pid_t   done_pid
);

    localparam int PTR_BITS = (N_OUTSTANDING > 1) ? $clog2(N_OUTSTANDING) : 1;
    localparam int CNT_BITS = $clog2(N_OUTSTANDING + 1);

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [CNT_BITS-1:0] cnt_t;

    logic q_last [N_OUTSTANDING];
    pid_t q_pid  [N_OUTSTANDING];
    ptr_t head;
    ptr_t tail;
    cnt_t count;
    logic push;

    function automatic ptr_t next_ptr(input ptr_t p);
        return (p == ptr_t'(N_OUTSTANDING - 1)) ? '0 : p + 1'b1;
    endfunction

    // Stall while a handshake is open or the queue is full
    assign beat_ready = !dma_req && !dma_ack && (count < cnt_t'(N_OUTSTANDING));
    assign push       = beat_valid && beat_ready;

    // ----------------------------------------
    // DMA handshake
    // ----------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            dma_req <= 1'b0;
        end else if (push) begin
            dma_req <= 1'b1;
        end else if (dma_ack) begin
            dma_req <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (push) begin
            dma_paddr    <= beat_paddr;
            dma_len      <= beat_len;
            dma_last     <= beat_last;
            q_last[tail] <= beat_last;
            q_pid[tail]  <= beat_pid;
        end
    end

    // ----------------------------------------
    // Outstanding queue
    // ----------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            head       <= '0;
            tail       <= '0;
            count      <= '0;
            done_valid <= 1'b0;
        end else begin
            if (push) begin
                tail <= next_ptr(tail);
            end
            if (dma_done) begin
                head <= next_ptr(head);
            end
            case ({push, dma_done})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            done_valid <= dma_done && q_last[head];
        end
    end

    always_ff @(posedge aclk) begin
        done_pid <= q_pid[head];
    end

endmodule

//--- logic/xlat_fsm.sv
// Request FSM with per-page lookup, page splitting and fault reporting
module xlat_fsm import xlat_pkg::*; (
    input  logic   aclk,
    input  logic   aresetn,

    // Requests
    input  logic   xreq_req,
    output logic   xreq_ack,
    input  pid_t   xreq_pid,
    input  vaddr_t xreq_vaddr,
    input  len_t   xreq_len,
    input  logic   xreq_last,

    // TLB lookup
    output logic   lup_req,
    input  logic   lup_ack,
    output pid_t   lup_pid,
    output vpn_t   lup_vpn,
    input  logic   lup_hit,
    input  ppn_t   lup_ppn,

    // Page fault
    output logic   pfault_req,
    input  logic   pfault_ack,
    output pid_t   pfault_pid,
    output vaddr_t pfault_vaddr,
    output len_t   pfault_len,

    // Beats to the output side
    output logic   beat_valid,
    input  logic   beat_ready,
    output paddr_t beat_paddr,
    output len_t   beat_len,
    output logic   beat_last,
    output pid_t   beat_pid
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ACCEPT,
        ST_LOOKUP,
        ST_RELEASE,
        ST_COMPUTE,
        ST_SEND,
        ST_FAULT,
        ST_FAULT_REL
    } xlat_state_t;

    xlat_state_t state;

    // Current request, advanced page by page
    pid_t   pid_r;
    vaddr_t vaddr_r;
    len_t   len_r;
    logic   last_r;

    // Captured lookup result
    logic   hit_r;
    ppn_t   ppn_r;

    offs_t  offs;
    len_t   page_rem;
    len_t   blen;

    // ----------------------------------------
    // Splitting
    // ----------------------------------------
    assign offs     = vaddr_r[PAGE_BITS-1:0];
    assign page_rem = len_t'(PAGE_SIZE) - len_t'(offs);
    assign blen     = (len_r < page_rem) ? len_r : page_rem;

    assign lup_pid      = pid_r;
    assign lup_vpn      = vaddr_r[VADDR_BITS-1:PAGE_BITS];
    assign pfault_pid   = pid_r;
    assign pfault_vaddr = vaddr_r;
    assign pfault_len   = len_r;
    assign beat_pid     = pid_r;

    // ----------------------------------------
    // Control
    // ----------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state      <= ST_IDLE;
            xreq_ack   <= 1'b0;
            lup_req    <= 1'b0;
            pfault_req <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (xreq_req) begin
                        xreq_ack <= 1'b1;
                        state    <= ST_ACCEPT;
                    end
                end
                // Work starts once the requester lets go
                ST_ACCEPT: begin
                    if (!xreq_req) begin
                        xreq_ack <= 1'b0;
                        if (len_r == '0) begin
                            state <= ST_IDLE;
                        end else begin
                            lup_req <= 1'b1;
                            state   <= ST_LOOKUP;
                        end
                    end
                end
                ST_LOOKUP: begin
                    if (lup_ack) begin
                        lup_req <= 1'b0;
                        state   <= ST_RELEASE;
                    end
                end
                ST_RELEASE: begin
                    if (!lup_ack) begin
                        if (hit_r) begin
                            state <= ST_COMPUTE;
                        end else begin
                            pfault_req <= 1'b1;
                            state      <= ST_FAULT;
                        end
                    end
                end
                ST_COMPUTE: begin
                    beat_valid <= 1'b1;
                    state      <= ST_SEND;
                end
                ST_SEND: begin
                    if (beat_ready) begin
                        beat_valid <= 1'b0;
                        if (len_r == '0) begin
                            state <= ST_IDLE;
                        end else begin
                            lup_req <= 1'b1;
                            state   <= ST_LOOKUP;
                        end
                    end
                end
                ST_FAULT: begin
                    if (pfault_ack) begin
                        pfault_req <= 1'b0;
                        state      <= ST_FAULT_REL;
                    end
                end
                // Retry the same page after the host installs it
                ST_FAULT_REL: begin
                    if (!pfault_ack) begin
                        lup_req <= 1'b1;
                        state   <= ST_LOOKUP;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Datapath
    // ----------------------------------------
    always_ff @(posedge aclk) begin
        case (state)
            ST_IDLE: begin
                if (xreq_req) begin
                    pid_r   <= xreq_pid;
                    vaddr_r <= xreq_vaddr;
                    len_r   <= xreq_len;
                    last_r  <= xreq_last;
                end
            end
            ST_LOOKUP: begin
                if (lup_ack) begin
                    hit_r <= lup_hit;
                    ppn_r <= lup_ppn;
                end
            end
            ST_COMPUTE: begin
                beat_paddr <= {ppn_r, offs};
                beat_len   <= blen;
                // Last beat of a request marked last
                beat_last  <= last_r && (len_r == blen);
                vaddr_r    <= vaddr_r + vaddr_t'(blen);
                len_r      <= len_r - blen;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/xlat_top.sv
// Translation engine top level with TLB, FSM and DMA issue instances
module xlat_top import xlat_pkg::*; #(
    parameter int TLB_ORDER     = 4,
    parameter int N_OUTSTANDING = 4
) (
    input  logic   aclk,
    input  logic   aresetn,

    // Host map port
    input  logic   map_req,
    output logic   map_ack,
    input  pid_t   map_pid,
    input  vpn_t   map_vpn,
    input  ppn_t   map_ppn,

    // Requests
    input  logic   xreq_req,
    output logic   xreq_ack,
    input  pid_t   xreq_pid,
    input  vaddr_t xreq_vaddr,
    input  len_t   xreq_len,
    input  logic   xreq_last,

    // Page faults
    output logic   pfault_req,
    input  logic   pfault_ack,
    output pid_t   pfault_pid,
    output vaddr_t pfault_vaddr,
    output len_t   pfault_len,

    // DMA
    output logic   dma_req,
    input  logic   dma_ack,
    output paddr_t dma_paddr,
    output len_t   dma_len,
    output logic   dma_last,
    input  logic   dma_done,

    // Completions
    output logic   done_valid,
    output pid_t   done_pid
);

    logic   lup_req;
    logic   lup_ack;
    pid_t   lup_pid;
    vpn_t   lup_vpn;
    logic   lup_hit;
    ppn_t   lup_ppn;

    logic   beat_valid;
    logic   beat_ready;
    paddr_t beat_paddr;
    len_t   beat_len;
    logic   beat_last;
    pid_t   beat_pid;

    tlb_table #(
        .TLB_ORDER (TLB_ORDER)
    ) i_tlb_table (
        .aclk    (aclk),
        .aresetn (aresetn),
        .map_req (map_req),
        .map_ack (map_ack),
        .map_pid (map_pid),
        .map_vpn (map_vpn),
        .map_ppn (map_ppn),
        .lup_req (lup_req),
        .lup_ack (lup_ack),
        .lup_pid (lup_pid),
        .lup_vpn (lup_vpn),
        .lup_hit (lup_hit),
        .lup_ppn (lup_ppn)
    );

    xlat_fsm i_xlat_fsm (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .xreq_req     (xreq_req),
        .xreq_ack     (xreq_ack),
        .xreq_pid     (xreq_pid),
        .xreq_vaddr   (xreq_vaddr),
        .xreq_len     (xreq_len),
        .xreq_last    (xreq_last),
        .lup_req      (lup_req),
        .lup_ack      (lup_ack),
        .lup_pid      (lup_pid),
        .lup_vpn      (lup_vpn),
        .lup_hit      (lup_hit),
        .lup_ppn      (lup_ppn),
        .pfault_req   (pfault_req),
        .pfault_ack   (pfault_ack),
        .pfault_pid   (pfault_pid),
        .pfault_vaddr (pfault_vaddr),
        .pfault_len   (pfault_len),
        .beat_valid   (beat_valid),
        .beat_ready   (beat_ready),
        .beat_paddr   (beat_paddr),
        .beat_len     (beat_len),
        .beat_last    (beat_last),
        .beat_pid     (beat_pid)
    );

    dma_issue #(
        .N_OUTSTANDING (N_OUTSTANDING)
    ) i_dma_issue (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .beat_paddr (beat_paddr),
        .beat_len   (beat_len),
        .beat_last  (beat_last),
        .beat_pid   (beat_pid),
        .dma_req    (dma_req),
        .dma_ack    (dma_ack),
        .dma_paddr  (dma_paddr),
        .dma_len    (dma_len),
        .dma_last   (dma_last),
        .dma_done   (dma_done),
        .done_valid (done_valid),
        .done_pid   (done_pid)
    );

endmodule

//--- project.f
+incdir+verif
common/xlat_pkg.sv
tlb/tlb_table.sv
logic/xlat_fsm.sv
logic/dma_issue.sv
logic/xlat_top.sv
verif/tb_xlat.sv

//--- tlb/tlb_table.sv
// Direct-mapped TLB with host map port and registered lookup port
module tlb_table import xlat_pkg::*; #(
    parameter int TLB_ORDER = 4
) (
    input  logic aclk,
    input  logic aresetn,

    // Host install
    input  logic map_req,
    output logic map_ack,
    input  pid_t map_pid,
    input  vpn_t map_vpn,
    input  ppn_t map_ppn,

    // Lookup from the FSM
    input  logic lup_req,
    output logic lup_ack,
    input  pid_t lup_pid,
    input  vpn_t lup_vpn,
    output logic lup_hit,
    output ppn_t lup_ppn
);

    localparam int N_ENTRIES = 1 << TLB_ORDER;
    localparam int TAG_BITS  = PID_BITS + VPN_BITS - TLB_ORDER;

    typedef logic [TAG_BITS-1:0]  tag_t;
    typedef logic [TLB_ORDER-1:0] idx_t;

    // ----------------------------------------
    // Storage
    // ----------------------------------------
    logic [N_ENTRIES-1:0] entry_valid;
    tag_t                 entry_tag [N_ENTRIES];
    ppn_t                 entry_ppn [N_ENTRIES];

    idx_t map_idx;
    tag_t map_tag;
    idx_t lup_idx;
    tag_t lup_tag;

    // Low vpn bits index, the rest plus pid form the tag
    assign map_idx = map_vpn[TLB_ORDER-1:0];
    assign map_tag = {map_pid, map_vpn[VPN_BITS-1:TLB_ORDER]};
    assign lup_idx = lup_vpn[TLB_ORDER-1:0];
    assign lup_tag = {lup_pid, lup_vpn[VPN_BITS-1:TLB_ORDER]};

    // ----------------------------------------
    // Map handshake and install
    // ----------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            map_ack     <= 1'b0;
            entry_valid <= '0;
        end else if (map_req && !map_ack) begin
            map_ack              <= 1'b1;
            entry_valid[map_idx] <= 1'b1;
        end else if (!map_req && map_ack) begin
            map_ack <= 1'b0;
        end
    end

    // Tag and ppn written with the valid bit, overwriting the slot
    always_ff @(posedge aclk) begin
        if (map_req && !map_ack) begin
            entry_tag[map_idx] <= map_tag;
            entry_ppn[map_idx] <= map_ppn;
        end
    end

    // ----------------------------------------
    // Lookup handshake
    // ----------------------------------------
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            lup_ack <= 1'b0;
        end else if (lup_req && !lup_ack) begin
            lup_ack <= 1'b1;
        end else if (!lup_req && lup_ack) begin
            lup_ack <= 1'b0;
        end
    end

    // Result held stable while ack is high
    always_ff @(posedge aclk) begin
        if (lup_req && !lup_ack) begin
            lup_hit <= entry_valid[lup_idx] && (entry_tag[lup_idx] == lup_tag);
            lup_ppn <= entry_ppn[lup_idx];
        end
    end

endmodule

//--- verif/xlat_model.svh
// Testbench model with LFSR, reference TLB, expected queues and compare tasks
`ifndef XLAT_MODEL_SVH
`define XLAT_MODEL_SVH

localparam int MAX_ENTRIES = 256;

logic [31:0] lfsr_state = 32'd66540;

// Reference TLB, direct mapped like the real one
logic m_valid [MAX_ENTRIES];
pid_t m_pid   [MAX_ENTRIES];
vpn_t m_vpn   [MAX_ENTRIES];

beat_t  exp_beats  [$];
fault_t exp_faults [$];
pid_t   exp_done   [$];

// ----------------------------------------
// Random source
// ----------------------------------------
function automatic logic lfsr_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return lsb;
endfunction

function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    int i;
    v = 0;
    for (i = 0; i < n; i++) begin
        v = (v << 1) | int'(lfsr_bit());
    end
    return v;
endfunction

// ----------------------------------------
// Reference TLB
// ----------------------------------------
// Fixed frame for every page so installs are repeatable
function automatic ppn_t page_frame(input pid_t pid, input vpn_t vpn);
    return ppn_t'(24'h40_0000) | ppn_t'({pid, 4'h0, vpn[11:0]});
endfunction

function automatic void model_install(input pid_t pid, input vpn_t vpn);
    int idx;
    idx = int'(vpn) & (n_entries - 1);
    m_valid[idx] = 1'b1;
    m_pid[idx]   = pid;
    m_vpn[idx]   = vpn;
endfunction

// Expected faults, beats and completions of one request, page by page
function automatic void predict_request(input pid_t pid, input vaddr_t vaddr,
                                        input len_t len, input logic last);
    vaddr_t va;
    len_t   rem;
    len_t   room;
    len_t   blen;
    vpn_t   vpn;
    logic   is_last;
    int     idx;
    va  = vaddr;
    rem = len;
    while (rem != '0) begin
        vpn = va[VADDR_BITS-1:PAGE_BITS];
        idx = int'(vpn) & (n_entries - 1);
        if (!(m_valid[idx] && m_pid[idx] == pid && m_vpn[idx] == vpn)) begin
            exp_faults.push_back({pid, va, rem});
            // Host brings the page in before the retry
            model_install(pid, vpn);
        end
        room    = len_t'(PAGE_SIZE) - len_t'(va[PAGE_BITS-1:0]);
        blen    = (rem < room) ? rem : room;
        is_last = last && (rem == blen);
        exp_beats.push_back({page_frame(pid, vpn), va[PAGE_BITS-1:0], blen, is_last});
        if (is_last) begin
            exp_done.push_back(pid);
        end
        rem = rem - blen;
        va  = va + vaddr_t'(blen);
    end
endfunction

// ----------------------------------------
// Compare tasks
// ----------------------------------------
task automatic check_low(input string name, input logic got);
    if (got !== 1'b0) begin
        stop_run($sformatf("Fail %0t %s got %b expected 0", $time, name, got));
    end
endtask

task automatic check_beat(input paddr_t paddr, input len_t len, input logic last);
    beat_t exp;
    if (exp_beats.size() == 0) begin
        stop_run($sformatf("Unexpected DMA beat to %h at %0t", paddr, $time));
    end
    exp = exp_beats.pop_front();
    if (paddr !== exp.paddr) begin
        stop_run($sformatf("Fail %0t dma_paddr got %h expected %h", $time, paddr, exp.paddr));
    end
    if (len !== exp.len) begin
        stop_run($sformatf("Fail %0t dma_len got %0d expected %0d", $time, len, exp.len));
    end
    if (last !== exp.last) begin
        stop_run($sformatf("Fail %0t dma_last got %b expected %b", $time, last, exp.last));
    end
endtask

task automatic check_fault(input pid_t pid, input vaddr_t vaddr, input len_t len);
    fault_t exp;
    if (exp_faults.size() == 0) begin
        stop_run($sformatf("Unexpected page fault at %h, time %0t", vaddr, $time));
    end
    exp = exp_faults.pop_front();
    if (pid !== exp.pid) begin
        stop_run($sformatf("Fail %0t pfault_pid got %h expected %h", $time, pid, exp.pid));
    end
    if (vaddr !== exp.vaddr) begin
        stop_run($sformatf("Fail %0t pfault_vaddr got %h expected %h",
                           $time, vaddr, exp.vaddr));
    end
    if (len !== exp.len) begin
        stop_run($sformatf("Fail %0t pfault_len got %0d expected %0d", $time, len, exp.len));
    end
endtask

task automatic check_done(input pid_t pid);
    pid_t exp;
    if (exp_done.size() == 0) begin
        stop_run($sformatf("Completion pulse with none expected at %0t", $time));
    end
    exp = exp_done.pop_front();
    if (pid !== exp) begin
        stop_run($sformatf("Fail %0t done_pid got %h expected %h", $time, pid, exp));
    end
endtask

`endif

//--- verif/tb_xlat.sv
// Testbench top with clock, reset, request driver, fault and DMA responders
module tb_xlat import xlat_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int     N_REQUESTS = 200;
    localparam int     WAIT_LIMIT = 5000;
    localparam vaddr_t REGION     = 32'h1000_0000;

    logic   aclk = 1'b0;
    logic   aresetn;
    logic   map_req;
    logic   map_ack;
    pid_t   map_pid;
    vpn_t   map_vpn;
    ppn_t   map_ppn;
    logic   xreq_req;
    logic   xreq_ack;
    pid_t   xreq_pid;
    vaddr_t xreq_vaddr;
    len_t   xreq_len;
    logic   xreq_last;
    logic   pfault_req;
    logic   pfault_ack;
    pid_t   pfault_pid;
    vaddr_t pfault_vaddr;
    len_t   pfault_len;
    logic   dma_req;
    logic   dma_ack;
    paddr_t dma_paddr;
    len_t   dma_len;
    logic   dma_last;
    logic   dma_done;
    logic   done_valid;
    pid_t   done_pid;

    int n_entries;
    int n_out;
    // Beats seen on dma and not yet completed, and completions still owed
    int outstanding;
    int pending;

    `include "xlat_model.svh"

    xlat_top i_dut (.*);

    always #5 aclk = ~aclk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_idle();
        check_low("map_ack", map_ack);
        check_low("xreq_ack", xreq_ack);
        check_low("pfault_req", pfault_req);
        check_low("dma_req", dma_req);
        check_low("done_valid", done_valid);
    endtask

    // Map port install, four-phase
    task automatic install_page(input pid_t pid, input vpn_t vpn);
        int n;
        map_pid = pid;
        map_vpn = vpn;
        map_ppn = page_frame(pid, vpn);
        map_req = 1'b1;
        for (n = 0; n < WAIT_LIMIT && !map_ack; n++) @(negedge aclk);
        if (!map_ack) stop_run("map_ack never rose during an install");
        map_req = 1'b0;
        for (n = 0; n < WAIT_LIMIT && map_ack; n++) @(negedge aclk);
        if (map_ack) stop_run("map_ack never fell after an install");
    endtask

    task automatic send_request(input pid_t pid, input vaddr_t va, input len_t len,
                                input logic last);
        int n;
        xreq_pid   = pid;
        xreq_vaddr = va;
        xreq_len   = len;
        xreq_last  = last;
        xreq_req   = 1'b1;
        for (n = 0; n < WAIT_LIMIT && !xreq_ack; n++) @(negedge aclk);
        if (!xreq_ack) stop_run("xreq_ack never rose for a request");
        xreq_req = 1'b0;
        for (n = 0; n < WAIT_LIMIT && xreq_ack; n++) @(negedge aclk);
        if (xreq_ack) stop_run("xreq_ack never fell after a request");
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin
        int     i;
        int     n;
        pid_t   pid;
        vaddr_t va;
        len_t   len;
        logic   last;
        aresetn    = 1'b0;
        map_req    = 1'b0;
        map_pid    = '0;
        map_vpn    = '0;
        map_ppn    = '0;
        xreq_req   = 1'b0;
        xreq_pid   = '0;
        xreq_vaddr = '0;
        xreq_len   = '0;
        xreq_last  = 1'b0;
        pfault_ack = 1'b0;
        dma_ack    = 1'b0;
        dma_done   = 1'b0;
        n_entries   = 1 << i_dut.TLB_ORDER;
        n_out       = i_dut.N_OUTSTANDING;
        outstanding = 0;
        pending     = 0;
        for (i = 0; i < MAX_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end
        repeat (4) begin
            @(negedge aclk);
            check_idle();
        end
        aresetn = 1'b1;
        repeat (2) begin
            @(negedge aclk);
            check_idle();
        end
        // One page per TLB slot, random pid, so about half the pages hit
        for (i = 0; i < n_entries; i++) begin
            pid = pid_t'(rand_bits(1));
            model_install(pid, vpn_t'(REGION >> PAGE_BITS) + vpn_t'(i));
            install_page(pid, vpn_t'(REGION >> PAGE_BITS) + vpn_t'(i));
        end
        for (i = 0; i < N_REQUESTS; i++) begin
            pid  = pid_t'(rand_bits(1));
            va   = REGION + vaddr_t'(rand_bits(12));
            len  = (rand_bits(3) == 0) ? len_t'(0) : len_t'(rand_bits(10) % 701);
            last = logic'(rand_bits(1));
            predict_request(pid, va, len, last);
            send_request(pid, va, len, last);
        end
        for (n = 0; n < WAIT_LIMIT && (exp_beats.size() + exp_faults.size()
                                      + exp_done.size() + pending) != 0; n++) begin
            @(negedge aclk);
        end
        repeat (4) @(negedge aclk);
        if (exp_beats.size() == 0 && exp_faults.size() == 0 && exp_done.size() == 0
            && pending == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            stop_run($sformatf("Run ended with %0d beats, %0d faults, %0d completions missing",
                               exp_beats.size(), exp_faults.size(), exp_done.size()));
        end
    end

    // ----------------------------------------
    // Responders and monitors
    // ----------------------------------------
    initial begin
        int n;
        forever begin
            @(negedge aclk);
            if (aresetn && pfault_req === 1'b1 && !pfault_ack) begin
                check_fault(pfault_pid, pfault_vaddr, pfault_len);
                install_page(pfault_pid, pfault_vaddr[VADDR_BITS-1:PAGE_BITS]);
                pfault_ack = 1'b1;
                for (n = 0; n < WAIT_LIMIT && pfault_req; n++) @(negedge aclk);
                if (pfault_req) stop_run("pfault_req never fell after ack");
                pfault_ack = 1'b0;
            end
        end
    end

    initial begin
        int n;
        forever begin
            @(negedge aclk);
            if (aresetn && dma_req === 1'b1 && !dma_ack) begin
                check_beat(dma_paddr, dma_len, dma_last);
                outstanding++;
                if (outstanding > n_out) begin
                    stop_run($sformatf("%0d beats outstanding at %0t, limit is %0d",
                                       outstanding, $time, n_out));
                end
                pending++;
                repeat (rand_bits(3)) @(negedge aclk);
                dma_ack = 1'b1;
                for (n = 0; n < WAIT_LIMIT && dma_req; n++) @(negedge aclk);
                if (dma_req) stop_run("dma_req never fell after ack");
                dma_ack = 1'b0;
            end
        end
    end

    // Completions in issue order, slower than issue so the queue fills up
    initial begin
        forever begin
            @(negedge aclk);
            if (pending > 0) begin
                repeat (rand_bits(4)) @(negedge aclk);
                dma_done = 1'b1;
                pending--;
                outstanding--;
                @(negedge aclk);
                dma_done = 1'b0;
            end
        end
    end

    always @(negedge aclk) begin
        if (aresetn && done_valid === 1'b1) begin
            check_done(done_pid);
        end
    end

endmodule
